// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_overlay_top
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/overlay_pkg.sv ====
/*
 * shared definitions for the video overlay path
 *   color and dimension widths
 *   pixel word and overlay word layouts
 *   default top-level parameter values
 */
package overlay_pkg;

  // ====================
  // widths
  // ====================
  localparam int COLOR_W = 8;   // bits per color channel
  localparam int DIM_W   = 16;  // width / height counts

  // receiver pixel, msb is red
  typedef struct packed {
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } pixel_t;

  // overlay word, key byte on top, bit 7 of key is the key flag
  typedef struct packed {
    logic [7:0]         key;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } ovl_word_t;

  // ====================
  // defaults
  // ====================
  localparam int FIFO_DEPTH_DEF     = 16;
  localparam int HEARTBEAT_HALF_DEF = 25000000;  // 0.5 s at 50 MHz
  localparam int STRIPE_BIT         = 3;         // 8 pixel wide stripes
  localparam int SEG_DIGITS         = 6;

endpackage

// ==== design/dvi_capture.sv ====
/*
 * receiver input stage
 *   one register stage on sync, de and pixel
 *   active width per line, latched when de falls
 *   active line count per frame, latched when vsync rises
 */
`timescale 1ns/1ps

module dvi_capture (
  input  logic                          odck_to_overlay,
  input  logic                          hps_fpga_reset_n,
  input  logic                          vsync_i,
  input  logic                          hsync_i,
  input  logic                          de_i,
  input  overlay_pkg::pixel_t           pixel_i,
  output logic                          vsync_o,
  output logic                          hsync_o,
  output logic                          de_o,
  output overlay_pkg::pixel_t           pixel_o,
  output logic [overlay_pkg::DIM_W-1:0] width_o,
  output logic [overlay_pkg::DIM_W-1:0] height_o
);

  logic                          de_d;      // registered de, one more stage
  logic                          vsync_d;
  logic                          de_fall;
  logic                          vsync_rise;
  logic [overlay_pkg::DIM_W-1:0] pix_cnt;   // de-high cycles this line
  logic [overlay_pkg::DIM_W-1:0] line_cnt;  // lines with de this frame

  // ====================
  // input register
  // ====================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      vsync_o <= 1'b0;
      hsync_o <= 1'b0;
      de_o    <= 1'b0;
    end
    else
    begin
      vsync_o <= vsync_i;
      hsync_o <= hsync_i;
      de_o    <= de_i;
    end
  end

  always_ff @(posedge odck_to_overlay)
  begin
    pixel_o <= pixel_i;  // payload only
  end

  // ====================
  // resolution measure
  // ====================
  assign de_fall    = de_d & ~de_o;
  assign vsync_rise = vsync_o & ~vsync_d;

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      de_d     <= 1'b0;
      vsync_d  <= 1'b0;
      pix_cnt  <= '0;
      line_cnt <= '0;
      width_o  <= '0;
      height_o <= '0;
    end
    else
    begin
      de_d    <= de_o;
      vsync_d <= vsync_o;
      if (de_o)
        pix_cnt <= pix_cnt + 1'b1;
      else if (de_fall)
      begin
        width_o <= pix_cnt;  // full line just ended
        pix_cnt <= '0;
      end
      // frame boundary, a line ending on the same cycle opens the new count
      if (vsync_rise)
      begin
        height_o <= line_cnt;
        line_cnt <= {{(overlay_pkg::DIM_W-1){1'b0}}, de_fall};
      end
      else if (de_fall)
        line_cnt <= line_cnt + 1'b1;
    end
  end

endmodule

// ==== design/heartbeat.sv ====
/*
 * blink led, toggles every HALF_PERIOD clocks
 */
`timescale 1ns/1ps

module heartbeat #(
  parameter int HALF_PERIOD = 25000000
) (
  input  logic odck_to_overlay,
  input  logic hps_fpga_reset_n,
  output logic led_o
);

  localparam int CNT_W = $clog2(HALF_PERIOD + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt   <= '0;
      led_o <= 1'b0;
    end
    else if (cnt == CNT_W'(HALF_PERIOD - 1))
    begin
      cnt   <= '0;       // wrap
      led_o <= ~led_o;
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule

// ==== design/overlay_top.sv ====
/*
 * video overlay top level
 *   receiver capture, overlay fifo, test pattern,
 *   mixer, resolution display, heartbeat
 */
`timescale 1ns/1ps

module overlay_top #(
  parameter int FIFO_DEPTH     = overlay_pkg::FIFO_DEPTH_DEF,
  parameter int HEARTBEAT_HALF = overlay_pkg::HEARTBEAT_HALF_DEF
) (
  input  logic                          odck_to_overlay,
  input  logic                          hps_fpga_reset_n,
  input  logic                          scdt_i,
  input  logic                          vsync_i,
  input  logic                          hsync_i,
  input  logic                          de_i,
  input  overlay_pkg::pixel_t           pixel_i,
  input  logic [4:0]                    sw_i,
  input  logic                          ovl_push_i,
  input  overlay_pkg::ovl_word_t        ovl_data_i,
  output logic                          vsync_o,
  output logic                          hsync_o,
  output logic                          de_o,
  output overlay_pkg::pixel_t           pixel_o,
  output logic                          blank_n_o,
  output logic [overlay_pkg::DIM_W-1:0] width_o,
  output logic [overlay_pkg::DIM_W-1:0] height_o,
  output logic [6:0]                    hex0_o,
  output logic [6:0]                    hex1_o,
  output logic [6:0]                    hex2_o,
  output logic [6:0]                    hex3_o,
  output logic [6:0]                    hex4_o,
  output logic [6:0]                    hex5_o,
  output logic                          led_heartbeat_o,
  output logic                          led_lock_o,
  output logic                          ovl_overflow_o
);

  // capture stage to mixer
  logic                   cap_vsync;
  logic                   cap_hsync;
  logic                   cap_de;
  overlay_pkg::pixel_t    cap_pixel;
  // overlay sources
  overlay_pkg::ovl_word_t fifo_data;
  logic                   fifo_empty;
  logic                   fifo_rd;
  overlay_pkg::ovl_word_t pattern_data;
  logic                   pattern_step;
  logic                   pattern_pause;

  assign led_lock_o = scdt_i;  // receiver lock straight to led

  dvi_capture dvi_capture_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .vsync_i          (vsync_i),
    .hsync_i          (hsync_i),
    .de_i             (de_i),
    .pixel_i          (pixel_i),
    .vsync_o          (cap_vsync),
    .hsync_o          (cap_hsync),
    .de_o             (cap_de),
    .pixel_o          (cap_pixel),
    .width_o          (width_o),
    .height_o         (height_o)
  );

  pixel_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) pixel_fifo_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .push_i           (ovl_push_i),
    .data_i           (ovl_data_i),
    .rd_i             (fifo_rd),
    .data_o           (fifo_data),
    .empty_o          (fifo_empty),
    .overflow_o       (ovl_overflow_o)
  );

  test_pattern_gen test_pattern_gen_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .vsync_i          (cap_vsync),      // same stage as the mixer input
    .step_i           (pattern_step),
    .pause_i          (pattern_pause),
    .data_o           (pattern_data)
  );

  overlay_mixer overlay_mixer_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .vsync_i          (cap_vsync),
    .hsync_i          (cap_hsync),
    .de_i             (cap_de),
    .pixel_i          (cap_pixel),
    .sw_i             (sw_i),
    .fifo_data_i      (fifo_data),
    .fifo_empty_i     (fifo_empty),
    .pattern_data_i   (pattern_data),
    .vsync_o          (vsync_o),
    .hsync_o          (hsync_o),
    .de_o             (de_o),
    .pixel_o          (pixel_o),
    .blank_n_o        (blank_n_o),
    .fifo_rd_o        (fifo_rd),
    .pattern_step_o   (pattern_step),
    .pause_o          (pattern_pause)
  );

  seg7_display seg7_display_inst (
    .width_i  (width_o),
    .height_i (height_o),
    .hex0_o   (hex0_o),
    .hex1_o   (hex1_o),
    .hex2_o   (hex2_o),
    .hex3_o   (hex3_o),
    .hex4_o   (hex4_o),
    .hex5_o   (hex5_o)
  );

  heartbeat #(
    .HALF_PERIOD (HEARTBEAT_HALF)
  ) heartbeat_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_o            (led_heartbeat_o)
  );

endmodule

// ==== design/seg7_display.sv ====
/*
 * resolution readout
 *   width on digits 5..3, height on digits 2..0
 *   hex glyphs, segments active low
 */
`timescale 1ns/1ps

module seg7_display (
  input  logic [overlay_pkg::DIM_W-1:0] width_i,
  input  logic [overlay_pkg::DIM_W-1:0] height_i,
  output logic [6:0]                    hex0_o,
  output logic [6:0]                    hex1_o,
  output logic [6:0]                    hex2_o,
  output logic [6:0]                    hex3_o,
  output logic [6:0]                    hex4_o,
  output logic [6:0]                    hex5_o
);

  logic [3:0] nibble [overlay_pkg::SEG_DIGITS];
  logic [6:0] seg    [overlay_pkg::SEG_DIGITS];

  // gfedcba, 0 lights the segment
  function automatic logic [6:0] hex_glyph(input logic [3:0] n);
    case (n)
      4'h0: hex_glyph = 7'b1000000;
      4'h1: hex_glyph = 7'b1111001;
      4'h2: hex_glyph = 7'b0100100;
      4'h3: hex_glyph = 7'b0110000;
      4'h4: hex_glyph = 7'b0011001;
      4'h5: hex_glyph = 7'b0010010;
      4'h6: hex_glyph = 7'b0000010;
      4'h7: hex_glyph = 7'b1111000;
      4'h8: hex_glyph = 7'b0000000;
      4'h9: hex_glyph = 7'b0010000;
      4'ha: hex_glyph = 7'b0001000;
      4'hb: hex_glyph = 7'b0000011;  // lower case b
      4'hc: hex_glyph = 7'b1000110;
      4'hd: hex_glyph = 7'b0100001;  // lower case d
      4'he: hex_glyph = 7'b0000110;
      default: hex_glyph = 7'b0001110;
    endcase
  endfunction

  // {width[11:0], height[11:0]}, digit 0 is the low nibble of height
  always_comb
  begin
    for (int i = 0; i < overlay_pkg::SEG_DIGITS; i++)
    begin
      nibble[i] = {width_i[11:0], height_i[11:0]}[i*4 +: 4];
      seg[i]    = hex_glyph(nibble[i]);
    end
  end

  assign hex0_o = seg[0];
  assign hex1_o = seg[1];
  assign hex2_o = seg[2];
  assign hex3_o = seg[3];
  assign hex4_o = seg[4];
  assign hex5_o = seg[5];

endmodule

// ==== overlay/overlay_mixer.sv ====
/*
 * overlay merge stage
 *   switch register
 *   overlay source select, fifo or test pattern
 *   keyed pixel merge and output register, blank_n
 */
`timescale 1ns/1ps

module overlay_mixer (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   vsync_i,
  input  logic                   hsync_i,
  input  logic                   de_i,
  input  overlay_pkg::pixel_t    pixel_i,
  input  logic [4:0]             sw_i,          // pause, test, -, enable, blank
  input  overlay_pkg::ovl_word_t fifo_data_i,
  input  logic                   fifo_empty_i,
  input  overlay_pkg::ovl_word_t pattern_data_i,
  output logic                   vsync_o,
  output logic                   hsync_o,
  output logic                   de_o,
  output overlay_pkg::pixel_t    pixel_o,
  output logic                   blank_n_o,
  output logic                   fifo_rd_o,
  output logic                   pattern_step_o,
  output logic                   pause_o
);

  logic                   sw_pause_q;
  logic                   sw_test_q;
  logic                   sw_en_q;
  logic                   sw_blank_q;
  overlay_pkg::ovl_word_t ovl_word;    // selected overlay word
  logic                   word_avail;
  logic                   consume;
  logic                   key_hit;

  // ====================
  // switches
  // ====================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sw_pause_q <= 1'b0;
      sw_test_q  <= 1'b0;
      sw_en_q    <= 1'b0;
      sw_blank_q <= 1'b0;
    end
    else
    begin
      sw_pause_q <= sw_i[4];
      sw_test_q  <= sw_i[3];
      sw_en_q    <= sw_i[1];
      sw_blank_q <= sw_i[0];  // sw_i[2] has no function here
    end
  end

  // ====================
  // source select
  // ====================
  assign ovl_word   = sw_test_q ? pattern_data_i : fifo_data_i;
  assign word_avail = sw_test_q | ~fifo_empty_i;  // pattern never runs dry
  assign consume    = de_i & sw_en_q & word_avail;
  assign key_hit    = consume & ovl_word.key[7];

  // show-ahead fifo, pop in the same cycle the word is used
  assign fifo_rd_o      = consume & ~sw_test_q;
  assign pattern_step_o = consume & sw_test_q;
  assign pause_o        = sw_pause_q;

  // ====================
  // merge register
  // ====================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      vsync_o   <= 1'b0;
      hsync_o   <= 1'b0;
      de_o      <= 1'b0;
      blank_n_o <= 1'b0;
    end
    else
    begin
      vsync_o   <= vsync_i;
      hsync_o   <= hsync_i;
      de_o      <= de_i;
      blank_n_o <= de_i & ~sw_blank_q;
    end
  end

  always_ff @(posedge odck_to_overlay)
  begin
    if (key_hit)
      pixel_o <= '{red: ovl_word.red, green: ovl_word.green, blue: ovl_word.blue};
    else
      pixel_o <= pixel_i;  // unkeyed or no word, video through
  end

endmodule

// ==== overlay/pixel_fifo.sv ====
/*
 * show-ahead fifo for the external overlay stream
 *   circular buffer, read/write pointers, fill count
 *   push to full is dropped, sticky overflow flag
 */
`timescale 1ns/1ps

module pixel_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   push_i,
  input  overlay_pkg::ovl_word_t data_i,
  input  logic                   rd_i,
  output overlay_pkg::ovl_word_t data_o,
  output logic                   empty_o,
  output logic                   overflow_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  overlay_pkg::ovl_word_t mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic                   full;
  logic                   do_wr;
  logic                   do_rd;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign do_wr   = push_i & ~full;
  assign do_rd   = rd_i & ~empty_o;
  assign data_o  = mem[rd_ptr];  // head word always on the output

  always_ff @(posedge odck_to_overlay)
  begin
    if (do_wr)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or both
      endcase
      if (push_i && full)
        overflow_o <= 1'b1;  // held until reset
    end
  end

endmodule

// ==== overlay/test_pattern_gen.sv ====
/*
 * built-in overlay source
 *   step count, cleared at each frame start
 *   gray ramp with keyed stripes
 */
`timescale 1ns/1ps

module test_pattern_gen (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   vsync_i,
  input  logic                   step_i,
  input  logic                   pause_i,
  output overlay_pkg::ovl_word_t data_o
);

  logic                          vsync_d;
  logic [overlay_pkg::DIM_W-1:0] step_cnt;

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      vsync_d  <= 1'b0;
      step_cnt <= '0;
    end
    else
    begin
      vsync_d <= vsync_i;
      if (vsync_i && !vsync_d)
        step_cnt <= '0;  // new frame
      else if (step_i && !pause_i)
        step_cnt <= step_cnt + 1'b1;
    end
  end

  // gray level from low bits, key flag from the stripe bit
  assign data_o.key   = {step_cnt[overlay_pkg::STRIPE_BIT], 7'b0};
  assign data_o.red   = step_cnt[overlay_pkg::COLOR_W-1:0];
  assign data_o.green = step_cnt[overlay_pkg::COLOR_W-1:0];
  assign data_o.blue  = step_cnt[overlay_pkg::COLOR_W-1:0];

endmodule

// ==== tests/tb_overlay_top.sv ====
/*
 * testbench for overlay_top
 *   stimulus table applied in a loop, video frame model
 *   reference fifo and test pattern model, 2 cycle output check
 *   resolution, hex digits, overflow, heartbeat and lock checks
 *   watchdog sized from the table
 */
`timescale 1ns/1ps

module tb_overlay_top;

  localparam int FIFO_DEPTH = overlay_pkg::FIFO_DEPTH_DEF;
  localparam int HB_HALF    = 20;
  localparam int NUM_ROWS   = 7;

  // segments in gfedcba order and active low
  localparam logic [6:0] GLYPH [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
                                        7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21,
                                        7'h06, 7'h0e};

  typedef struct packed {
    logic [4:0]  sw;        // pause, test, -, enable, blank
    logic [15:0] w;         // active width
    logic [15:0] h;         // active lines
    logic [7:0]  pushes;    // words pushed before the frames
    logic [31:0] key_mask;  // key flag of each pushed word
  } row_t;

  logic                          odck_to_overlay;
  logic                          hps_fpga_reset_n;
  logic                          scdt_i;
  logic                          vsync_i;
  logic                          hsync_i;
  logic                          de_i;
  overlay_pkg::pixel_t           pixel_i;
  logic [4:0]                    sw_i;
  logic                          ovl_push_i;
  overlay_pkg::ovl_word_t        ovl_data_i;
  logic                          vsync_o;
  logic                          hsync_o;
  logic                          de_o;
  overlay_pkg::pixel_t           pixel_o;
  logic                          blank_n_o;
  logic [overlay_pkg::DIM_W-1:0] width_o;
  logic [overlay_pkg::DIM_W-1:0] height_o;
  logic [6:0]                    hex0_o;
  logic [6:0]                    hex1_o;
  logic [6:0]                    hex2_o;
  logic [6:0]                    hex3_o;
  logic [6:0]                    hex4_o;
  logic [6:0]                    hex5_o;
  logic                          led_heartbeat_o;
  logic                          led_lock_o;
  logic                          ovl_overflow_o;

  row_t                   rows [NUM_ROWS];
  logic [31:0]            lcg_state;
  logic [4:0]             sw_cur;     // switches for the next driven cycle
  logic                   scdt_cur;
  logic [27:0]            exp_q [$];  // {vsync, hsync, de, blank_n, pixel}
  overlay_pkg::ovl_word_t fifo_q [$]; // reference fifo
  logic [15:0]            pat_cnt;    // reference pattern step
  logic                   prev_vs;
  logic                   exp_ovf;
  int                     cyc_cnt;    // clocks since reset release
  int                     watchdog_cycles;
  int                     test_errors;
  int                     total_errors;
  int                     tests_run;
  int                     failed_tests;

  overlay_top #(
    .FIFO_DEPTH     (FIFO_DEPTH),
    .HEARTBEAT_HALF (HB_HALF)
  ) overlay_top_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .scdt_i           (scdt_i),
    .vsync_i          (vsync_i),
    .hsync_i          (hsync_i),
    .de_i             (de_i),
    .pixel_i          (pixel_i),
    .sw_i             (sw_i),
    .ovl_push_i       (ovl_push_i),
    .ovl_data_i       (ovl_data_i),
    .vsync_o          (vsync_o),
    .hsync_o          (hsync_o),
    .de_o             (de_o),
    .pixel_o          (pixel_o),
    .blank_n_o        (blank_n_o),
    .width_o          (width_o),
    .height_o         (height_o),
    .hex0_o           (hex0_o),
    .hex1_o           (hex1_o),
    .hex2_o           (hex2_o),
    .hex3_o           (hex3_o),
    .hex4_o           (hex4_o),
    .hex5_o           (hex5_o),
    .led_heartbeat_o  (led_heartbeat_o),
    .led_lock_o       (led_lock_o),
    .ovl_overflow_o   (ovl_overflow_o)
  );

  always #5 odck_to_overlay = ~odck_to_overlay;  // 10 ns period

  always @(posedge odck_to_overlay)
  begin
    if (!hps_fpga_reset_n)
      cyc_cnt <= 0;
    else
      cyc_cnt <= cyc_cnt + 1;
  end

  // ====================
  // helpers
  // ====================
  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // vsync 2, porch 3, per line hsync 2 + porch 2 + active + porch 2, tail 2
  function automatic int frame_cycles(input logic [15:0] w, input logic [15:0] h);
    return 7 + int'(h) * (int'(w) + 6);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
    else
    begin
      $display("Error: %s = %h, expected %h", name, got, want);
      test_errors++;
    end
  endtask

  // one clock of stimulus, reference model step, delayed output compare
  task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                             input logic push, input overlay_pkg::ovl_word_t word);
    logic [31:0]            r;
    overlay_pkg::pixel_t    pix;
    overlay_pkg::pixel_t    out_pix;
    overlay_pkg::ovl_word_t w;
    logic [27:0]            want;
    @(posedge odck_to_overlay);
    r   = next_rand();
    pix = r[31:8];
    vsync_i    <= vs;
    hsync_i    <= hs;
    de_i       <= de;
    pixel_i    <= pix;
    sw_i       <= sw_cur;
    scdt_i     <= scdt_cur;
    ovl_push_i <= push;
    ovl_data_i <= word;
    if (push)
    begin
      if (fifo_q.size() < FIFO_DEPTH)
        fifo_q.push_back(word);
      else
        exp_ovf = 1'b1;  // dropped
    end
    if (vs && !prev_vs)
      pat_cnt = 16'd0;  // frame start
    prev_vs = vs;
    out_pix = pix;
    if (de && sw_cur[1])
    begin
      if (sw_cur[3])
      begin
        if (pat_cnt[overlay_pkg::STRIPE_BIT])
          out_pix = {3{pat_cnt[7:0]}};  // gray stripe
        if (!sw_cur[4])
          pat_cnt++;
      end
      else if (fifo_q.size() > 0)
      begin
        w = fifo_q.pop_front();
        if (w.key[7])
          out_pix = {w.red, w.green, w.blue};
      end
    end
    exp_q.push_back({vs, hs, de, de & ~sw_cur[0], out_pix});
    @(negedge odck_to_overlay);
    check_val("led_heartbeat_o", 32'(led_heartbeat_o), 32'((cyc_cnt / HB_HALF) % 2));
    check_val("led_lock_o", 32'(led_lock_o), 32'(scdt_i));
    if (exp_q.size() == 3)
    begin
      want = exp_q.pop_front();  // driven 2 clocks back
      check_val("vsync_o", 32'(vsync_o), 32'(want[27]));
      check_val("hsync_o", 32'(hsync_o), 32'(want[26]));
      check_val("de_o", 32'(de_o), 32'(want[25]));
      check_val("blank_n_o", 32'(blank_n_o), 32'(want[24]));
      check_val("pixel_o", 32'(pixel_o), 32'(want[23:0]));
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic run_frame(input logic [15:0] w, input logic [15:0] h);
    repeat (2) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
    repeat (3) idle_cycle();
    for (int l = 0; l < int'(h); l++)
    begin
      repeat (2) drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
      repeat (2) idle_cycle();
      repeat (w) drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      repeat (2) idle_cycle();
    end
    repeat (2) idle_cycle();
  endtask

  task automatic check_resolution(input logic [15:0] w, input logic [15:0] h);
    check_val("width_o", 32'(width_o), 32'(w));
    check_val("height_o", 32'(height_o), 32'(h));
    check_val("hex5_o", 32'(hex5_o), 32'(GLYPH[w[11:8]]));
    check_val("hex4_o", 32'(hex4_o), 32'(GLYPH[w[7:4]]));
    check_val("hex3_o", 32'(hex3_o), 32'(GLYPH[w[3:0]]));
    check_val("hex2_o", 32'(hex2_o), 32'(GLYPH[h[11:8]]));
    check_val("hex1_o", 32'(hex1_o), 32'(GLYPH[h[7:4]]));
    check_val("hex0_o", 32'(hex0_o), 32'(GLYPH[h[3:0]]));
  endtask

  task automatic end_test(input int num, input string what);
    $display("test %0d (%s): %0d errors, %s", num, what, test_errors,
             (test_errors == 0) ? "ok" : "fail");
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0)
      failed_tests++;
    test_errors = 0;
  endtask

  // ====================
  // main sequence
  // ====================
  initial
  begin
    int                     total;
    logic [31:0]            r;
    logic [31:0]            mask_sh;
    overlay_pkg::ovl_word_t word;
    odck_to_overlay  = 1'b0;
    hps_fpga_reset_n = 1'b0;
    scdt_i     = 1'b0;
    vsync_i    = 1'b0;
    hsync_i    = 1'b0;
    de_i       = 1'b0;
    pixel_i    = '0;
    sw_i       = 5'b00000;
    ovl_push_i = 1'b0;
    ovl_data_i = '0;
    lcg_state  = 32'd99144;
    sw_cur     = 5'b00000;
    scdt_cur   = 1'b0;
    pat_cnt    = 16'd0;
    prev_vs    = 1'b0;
    exp_ovf    = 1'b0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    failed_tests = 0;
    // sw, width, lines, pushes, key mask
    rows[0] = {5'b00000, 16'd12,  16'd4,   8'd0,  32'h0000_0000};  // passthrough
    rows[1] = {5'b00001, 16'd9,   16'd359, 8'd0,  32'h0000_0000};  // blanked
    rows[2] = {5'b00010, 16'd10,  16'd5,   8'd7,  32'h0000_005b};  // external short run
    rows[3] = {5'b00110, 16'd222, 16'd2,   8'd16, 32'h0000_f0f0};  // external full fifo
    rows[4] = {5'b01010, 16'd40,  16'd4,   8'd0,  32'h0000_0000};  // test pattern
    rows[5] = {5'b11010, 16'd16,  16'd3,   8'd0,  32'h0000_0000};  // pattern paused
    rows[6] = {5'b01011, 16'd447, 16'd2,   8'd0,  32'h0000_0000};  // ramp wraps and blanked
    total = 16 + FIFO_DEPTH + 64;  // reset and overflow phases
    for (int t = 0; t < NUM_ROWS; t++)
      total = total + 2 * frame_cycles(rows[t].w, rows[t].h) + int'(rows[t].pushes) + 16;
    watchdog_cycles = 3 * total;

    // reset held 16 clocks
    repeat (16)
    begin
      @(posedge odck_to_overlay);
      @(negedge odck_to_overlay);
      check_val("de_o", 32'(de_o), 32'd0);
      check_val("blank_n_o", 32'(blank_n_o), 32'd0);
      check_val("led_heartbeat_o", 32'(led_heartbeat_o), 32'd0);
      check_val("ovl_overflow_o", 32'(ovl_overflow_o), 32'd0);
      check_val("width_o", 32'(width_o), 32'd0);
      check_val("height_o", 32'(height_o), 32'd0);
    end
    @(posedge odck_to_overlay);
    hps_fpga_reset_n <= 1'b1;
    repeat (2) idle_cycle();
    check_val("ovl_overflow_o", 32'(ovl_overflow_o), 32'd0);
    check_val("width_o", 32'(width_o), 32'd0);
    check_val("height_o", 32'(height_o), 32'd0);
    end_test(0, "reset");

    for (int t = 0; t < NUM_ROWS; t++)
    begin
      sw_cur   = rows[t].sw;
      scdt_cur = ~scdt_cur;
      repeat (4) idle_cycle();
      for (int i = 0; i < int'(rows[t].pushes); i++)
      begin
        r       = next_rand();
        mask_sh = rows[t].key_mask >> i;
        word    = {mask_sh[0], r[6:0], r[31:8]};  // key flag, random low key bits
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, word);
      end
      repeat (2) idle_cycle();
      repeat (2) run_frame(rows[t].w, rows[t].h);  // second frame latches height
      repeat (3) idle_cycle();
      check_resolution(rows[t].w, rows[t].h);
      check_val("ovl_overflow_o", 32'(ovl_overflow_o), 32'(exp_ovf));
      end_test(t + 1, $sformatf("sw %05b, %0dx%0d", rows[t].sw, rows[t].w, rows[t].h));
    end

    // one push past full with no frame to drain
    sw_cur   = 5'b00000;
    scdt_cur = ~scdt_cur;
    for (int i = 0; i <= FIFO_DEPTH; i++)
    begin
      r = next_rand();
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, r);
    end
    repeat (3) idle_cycle();
    check_val("ovl_overflow_o", 32'(ovl_overflow_o), 32'd1);
    scdt_cur = ~scdt_cur;
    repeat (40) idle_cycle();  // spans two heartbeat toggles
    check_val("ovl_overflow_o", 32'(ovl_overflow_o), 32'd1);
    end_test(NUM_ROWS + 1, "overflow, heartbeat, lock");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, total_errors);
    if (failed_tests == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // ====================
  // watchdog
  // ====================
  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge odck_to_overlay);
    $display("watchdog expired after %0d clocks, the run did not complete", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
common/overlay_pkg.sv
design/dvi_capture.sv
overlay/pixel_fifo.sv
overlay/test_pattern_gen.sv
overlay/overlay_mixer.sv
design/seg7_display.sv
design/heartbeat.sv
design/overlay_top.sv
tests/tb_overlay_top.sv
